// ==== cw_pkg.sv ====
package cw_pkg;

   // plain vectors with a meaning
   typedef logic [7:0]  reg_addr_t;    // host register address
   typedef logic [7:0]  reg_data_t;    // one host data byte
   typedef logic [15:0] trig_mask_t;   // trigger source register, see bit map below
   typedef logic [15:0] pwm_count_t;   // pwm counter or time value

   // host register map
   localparam reg_addr_t CW_TRIGSRC_ADDR        = 8'd39;
   localparam reg_addr_t CW_TRIGMOD_ADDR        = 8'd40;
   localparam reg_addr_t CW_IOROUTE_ADDR        = 8'd55;
   localparam reg_addr_t SOFTPOWER_CONTROL_ADDR = 8'd102;

   localparam int IOROUTE_EXTRA_BYTE = 5;   // only byte of ioroute kept
   localparam int POWER_OFF_BIT      = 1;   // EXTRA bit, 1 = target power off
   localparam int FAST_START_BIT     = 2;   // EXTRA bit, 1 = skip soft start

   // trigger source: [0] aux, [1] nrst, [5:2] io1..4, [7:6] combine, [15:8] userio
   localparam int         TRIGSRC_COMB_LSB = 6;
   localparam trig_mask_t TRIGSRC_PIN_MASK = 16'hff3f;   // pin enables only
   localparam trig_mask_t TRIGSRC_RESET    = 16'h0020;   // io4, OR mode

   typedef enum logic [1:0] {
      COMB_OR   = 2'd0,
      COMB_AND  = 2'd1,
      COMB_NAND = 2'd2,
      COMB_OFF  = 2'd3   // ext trigger held low
   } trig_comb_e;

   typedef enum logic [2:0] {
      MOD_EXT       = 3'd0,
      MOD_ADVIO     = 3'd1,
      MOD_SAD       = 3'd2,
      MOD_DECODEDIO = 3'd3,
      MOD_TRACE     = 3'd4,
      MOD_ADC       = 3'd5,
      MOD_EDGE      = 3'd6,
      MOD_NONE      = 3'd7
   } trig_mod_e;

   typedef struct packed {
      logic [7:0] userio;
      logic [3:0] io;     // io[0] is target io 1
      logic       nrst;
      logic       aux;
   } trig_pins_t;

   typedef struct packed {
      logic edge_trig;   // edge detector module
      logic adc;
      logic trace;
      logic decodedio;
      logic sad;
      logic advio;
   } trig_mods_t;

   // byte 0 is cycles1, byte 7 is the top of off_time2
   typedef struct packed {
      pwm_count_t off_time2;
      pwm_count_t off_time1;
      pwm_count_t period;
      logic [7:0] cycles2;
      logic [7:0] cycles1;
   } softpower_cfg_t;

   localparam softpower_cfg_t SOFTPOWER_RESET = {16'd0, 16'd1995, 16'd2000, 8'd0, 8'd35};

   typedef struct packed {
      logic fast_start;   // EXTRA bit 2
      logic power_off;    // EXTRA bit 1
   } power_ctrl_t;

   typedef enum logic [1:0] {
      SS_IDLE,
      SS_PHASE1,
      SS_PHASE2,
      SS_DONE
   } softstart_state_e;

endpackage

// ==== cw_regs.sv ====
`timescale 1ns/1ps

module cw_regs import cw_pkg::*; #(
   parameter int pBYTECNT_SIZE = 7
) (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  reg_addr_t                reg_address_i,
   input  logic [pBYTECNT_SIZE-1:0] reg_bytecnt_i,   // byte index in multi-byte regs
   input  reg_data_t                reg_datai_i,
   input  logic                     reg_read_i,
   input  logic                     reg_write_i,
   output reg_data_t                reg_datao_o,
   output trig_mask_t               trig_mask_o,
   output trig_mod_e                trig_mod_o,
   output power_ctrl_t              power_ctrl_o,
   output softpower_cfg_t           softpower_cfg_o
);

   trig_mask_t     trigsrc_q;     // 2 bytes
   reg_data_t      trigmod_q;     // upper bits kept for read-back only
   power_ctrl_t    power_q;       // the two live bits of the EXTRA byte
   softpower_cfg_t softpower_q;   // 8 bytes

   logic      trigsrc_byte_ok;   // byte index inside each register
   logic      trigmod_byte_ok;
   logic      extra_byte_ok;
   logic      softpower_byte_ok;
   reg_data_t extra_rd;          // EXTRA byte as seen by the host

   assign trigsrc_byte_ok   = reg_bytecnt_i < pBYTECNT_SIZE'(2);
   assign trigmod_byte_ok   = reg_bytecnt_i == '0;
   assign extra_byte_ok     = reg_bytecnt_i == pBYTECNT_SIZE'(IOROUTE_EXTRA_BYTE);
   assign softpower_byte_ok = reg_bytecnt_i < pBYTECNT_SIZE'(8);

   // host writes, one byte per strobe
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trigsrc_q   <= TRIGSRC_RESET;
         trigmod_q   <= '0;           // EXT mode
         power_q     <= '0;           // power on, slow start
         softpower_q <= SOFTPOWER_RESET;
      end else if (reg_write_i) begin
         case (reg_address_i)
            CW_TRIGSRC_ADDR: begin
               if (trigsrc_byte_ok)
                  trigsrc_q[{reg_bytecnt_i[0], 3'b000} +: 8] <= reg_datai_i;
            end
            CW_TRIGMOD_ADDR: begin
               if (trigmod_byte_ok)
                  trigmod_q <= reg_datai_i;
            end
            CW_IOROUTE_ADDR: begin
               // other ioroute bytes have no storage here
               if (extra_byte_ok) begin
                  power_q.power_off  <= reg_datai_i[POWER_OFF_BIT];
                  power_q.fast_start <= reg_datai_i[FAST_START_BIT];
               end
            end
            SOFTPOWER_CONTROL_ADDR: begin
               if (softpower_byte_ok)
                  softpower_q[{reg_bytecnt_i[2:0], 3'b000} +: 8] <= reg_datai_i;
            end
            default: ;   // unknown address, write dropped
         endcase
      end
   end

   always_comb begin
      extra_rd                 = '0;
      extra_rd[POWER_OFF_BIT]  = power_q.power_off;
      extra_rd[FAST_START_BIT] = power_q.fast_start;
   end

   // read mux, purely combinational
   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            CW_TRIGSRC_ADDR: begin
               if (trigsrc_byte_ok)
                  reg_datao_o = trigsrc_q[{reg_bytecnt_i[0], 3'b000} +: 8];
            end
            CW_TRIGMOD_ADDR: begin
               if (trigmod_byte_ok)
                  reg_datao_o = trigmod_q;
            end
            CW_IOROUTE_ADDR: begin
               if (extra_byte_ok)
                  reg_datao_o = extra_rd;
            end
            SOFTPOWER_CONTROL_ADDR: begin
               if (softpower_byte_ok)
                  reg_datao_o = softpower_q[{reg_bytecnt_i[2:0], 3'b000} +: 8];
            end
            default: reg_datao_o = '0;
         endcase
      end
   end

   assign trig_mask_o     = trigsrc_q;
   assign trig_mod_o      = trig_mod_e'(trigmod_q[2:0]);   // low 3 bits pick the module
   assign power_ctrl_o    = power_q;
   assign softpower_cfg_o = softpower_q;

endmodule

// ==== trig_route.sv ====
`timescale 1ns/1ps

module trig_route import cw_pkg::*; (
   input  trig_pins_t trig_pins_i,
   input  trig_mask_t trig_mask_i,
   input  trig_mod_e  trig_mod_i,
   input  trig_mods_t trig_mods_i,
   output logic       trigger_ext_o,
   output logic       trigger_capture_o,
   output logic       decodeio_active_o,
   output logic       sad_active_o,
   output logic       edge_trigger_active_o
);

   trig_mask_t pin_vec;    // pins lined up with the mask bits
   trig_mask_t pin_en;     // enables without the mode field
   trig_comb_e comb_mode;
   logic       trig_or;
   logic       trig_and;

   // bits 7:6 are the mode field, tie those pin slots low
   assign pin_vec = {trig_pins_i.userio, 2'b00, trig_pins_i.io,
                     trig_pins_i.nrst, trig_pins_i.aux};
   assign pin_en  = trig_mask_i & TRIGSRC_PIN_MASK;

   assign comb_mode = trig_comb_e'(trig_mask_i[TRIGSRC_COMB_LSB +: 2]);

   assign trig_or  = |(pin_vec & pin_en);
   assign trig_and = &(pin_vec | ~pin_en);   // disabled pins count as 1

   always_comb begin
      case (comb_mode)
         COMB_OR:   trigger_ext_o = trig_or;
         COMB_AND:  trigger_ext_o = trig_and;
         COMB_NAND: trigger_ext_o = ~trig_and;
         default:   trigger_ext_o = 1'b0;   // OFF
      endcase
   end

   // capture trigger source select
   always_comb begin
      case (trig_mod_i)
         MOD_EXT:       trigger_capture_o = trigger_ext_o;
         MOD_ADVIO:     trigger_capture_o = trig_mods_i.advio;
         MOD_SAD:       trigger_capture_o = trig_mods_i.sad;
         MOD_DECODEDIO: trigger_capture_o = trig_mods_i.decodedio;
         MOD_TRACE:     trigger_capture_o = trig_mods_i.trace;
         MOD_ADC:       trigger_capture_o = trig_mods_i.adc;
         MOD_EDGE:      trigger_capture_o = trig_mods_i.edge_trig;
         default:       trigger_capture_o = 1'b0;   // NONE
      endcase
   end

   // modules that need to know they own the trigger
   assign decodeio_active_o     = trig_mod_i == MOD_DECODEDIO;
   assign sad_active_o          = trig_mod_i == MOD_SAD;
   assign edge_trigger_active_o = trig_mod_i == MOD_EDGE;

endmodule

// ==== softstart_pwm.sv ====
`timescale 1ns/1ps

module softstart_pwm import cw_pkg::*; (
   input  logic           clk_usb,
   input  logic           reset,
   input  power_ctrl_t    power_ctrl_i,
   input  softpower_cfg_t softpower_cfg_i,
   output logic           targetpower_off_o
);

   softstart_state_e state_q;
   logic             power_off_d1;    // power-off bit one clock back
   logic             power_on_edge;   // power-off just cleared
   pwm_count_t       pwm_cnt;         // 0 .. period
   pwm_count_t       off_time;        // off window for current phase
   logic [7:0]       wrap_cnt;        // pwm periods done in this phase
   logic [7:0]       wrap_nxt;
   logic [7:0]       phase_cycles;    // periods the current phase lasts
   logic             pwm_wrap;
   logic             phase_end;
   logic             soft_active;

   assign power_on_edge = power_off_d1 & ~power_ctrl_i.power_off;

   // >= so a shrunk period cannot strand the counter
   assign pwm_wrap     = pwm_cnt >= softpower_cfg_i.period;
   assign wrap_nxt     = wrap_cnt + 8'd1;
   assign phase_cycles = (state_q == SS_PHASE1) ? softpower_cfg_i.cycles1
                                                : softpower_cfg_i.cycles2;
   assign phase_end    = pwm_wrap & (wrap_nxt >= phase_cycles);   // zero cycles still runs one

   always_ff @(posedge clk_usb) begin
      if (reset)
         power_off_d1 <= 1'b0;
      else
         power_off_d1 <= power_ctrl_i.power_off;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state_q  <= SS_IDLE;
         pwm_cnt  <= '0;
         wrap_cnt <= '0;
      end else if (power_ctrl_i.power_off) begin
         state_q  <= SS_IDLE;    // power off aborts any soft start
         pwm_cnt  <= '0;
         wrap_cnt <= '0;
      end else if (power_on_edge) begin
         state_q  <= SS_PHASE1;
         pwm_cnt  <= '0;
         wrap_cnt <= '0;
      end else if (state_q == SS_PHASE1 || state_q == SS_PHASE2) begin
         pwm_cnt <= pwm_wrap ? '0 : pwm_cnt + 16'd1;
         if (phase_end) begin
            wrap_cnt <= '0;
            if (state_q == SS_PHASE1 && softpower_cfg_i.cycles2 != 8'd0)
               state_q <= SS_PHASE2;
            else
               state_q <= SS_DONE;   // no second phase, or it just ended
         end else if (pwm_wrap) begin
            wrap_cnt <= wrap_nxt;
         end
      end
   end

   assign off_time = (state_q == SS_PHASE1) ? softpower_cfg_i.off_time1
                                            : softpower_cfg_i.off_time2;

   // pwm only while ramping in slow mode, power-off wins at once
   assign soft_active = ~power_ctrl_i.fast_start & ~power_ctrl_i.power_off &
                        (state_q == SS_PHASE1 || state_q == SS_PHASE2);

   assign targetpower_off_o = soft_active ? (pwm_cnt < off_time)
                                          : power_ctrl_i.power_off;

endmodule

// ==== cw_ctrl_top.sv ====
`timescale 1ns/1ps

module cw_ctrl_top import cw_pkg::*; #(
   parameter int pBYTECNT_SIZE = 7
) (
   input  logic                     clk_usb,
   input  logic                     reset,
   // host register port
   input  reg_addr_t                reg_address_i,
   input  logic [pBYTECNT_SIZE-1:0] reg_bytecnt_i,
   input  reg_data_t                reg_datai_i,
   input  logic                     reg_read_i,
   input  logic                     reg_write_i,
   output reg_data_t                reg_datao_o,
   // trigger side
   input  trig_pins_t               trig_pins_i,
   input  trig_mods_t               trig_mods_i,
   output logic                     trigger_ext_o,
   output logic                     trigger_capture_o,
   output logic                     decodeio_active_o,
   output logic                     sad_active_o,
   output logic                     edge_trigger_active_o,
   // target power
   output logic                     targetpower_off_o,
   output logic                     targetio_highz_o
);

   trig_mask_t     trig_mask;
   trig_mod_e      trig_mod;
   power_ctrl_t    power_ctrl;
   softpower_cfg_t softpower_cfg;

   cw_regs #(
      .pBYTECNT_SIZE (pBYTECNT_SIZE)
   ) u_regs (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .reg_address_i   (reg_address_i),
      .reg_bytecnt_i   (reg_bytecnt_i),
      .reg_datai_i     (reg_datai_i),
      .reg_read_i      (reg_read_i),
      .reg_write_i     (reg_write_i),
      .reg_datao_o     (reg_datao_o),
      .trig_mask_o     (trig_mask),
      .trig_mod_o      (trig_mod),
      .power_ctrl_o    (power_ctrl),
      .softpower_cfg_o (softpower_cfg)
   );

   trig_route u_trig_route (
      .trig_pins_i           (trig_pins_i),
      .trig_mask_i           (trig_mask),
      .trig_mod_i            (trig_mod),
      .trig_mods_i           (trig_mods_i),
      .trigger_ext_o         (trigger_ext_o),
      .trigger_capture_o     (trigger_capture_o),
      .decodeio_active_o     (decodeio_active_o),
      .sad_active_o          (sad_active_o),
      .edge_trigger_active_o (edge_trigger_active_o)
   );

   softstart_pwm u_softstart (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .power_ctrl_i      (power_ctrl),
      .softpower_cfg_i   (softpower_cfg),
      .targetpower_off_o (targetpower_off_o)
   );

   assign targetio_highz_o = power_ctrl.power_off;   // io floats while target unpowered

endmodule

// ==== cw_ctrl_top_chk.sv ====
`timescale 1ns/1ps

module cw_ctrl_top_chk import cw_pkg::*; (
   input logic      clk_usb,
   input logic      reset,
   input trig_mod_e trig_mod_i,
   input logic      trigger_capture_i,
   input logic      decodeio_active_i,
   input logic      sad_active_i,
   input logic      edge_trigger_active_i,
   input logic      targetpower_off_i,
   input logic      targetio_highz_i
);

   // only one module may own the capture trigger
   a_one_active: assert property (@(posedge clk_usb) disable iff (reset)
      $onehot0({decodeio_active_i, sad_active_i, edge_trigger_active_i}))
      else $error("more than one trigger module flagged active");

   // io floats only while the target is unpowered
   a_highz_off: assert property (@(posedge clk_usb) disable iff (reset)
      targetio_highz_i |-> targetpower_off_i)
      else $error("target io high-z while target power is on");

   a_none_quiet: assert property (@(posedge clk_usb) disable iff (reset)
      (trig_mod_i == MOD_NONE) |-> !trigger_capture_i)
      else $error("capture trigger high with no module selected");

endmodule

bind cw_ctrl_top cw_ctrl_top_chk u_chk (
   .clk_usb               (clk_usb),
   .reset                 (reset),
   .trig_mod_i            (trig_mod),   // internal select from the register file
   .trigger_capture_i     (trigger_capture_o),
   .decodeio_active_i     (decodeio_active_o),
   .sad_active_i          (sad_active_o),
   .edge_trigger_active_i (edge_trigger_active_o),
   .targetpower_off_i     (targetpower_off_o),
   .targetio_highz_i      (targetio_highz_o)
);

// ==== cw_ctrl_top_tb.sv ====
`timescale 1ns/1ps

module cw_ctrl_top_tb import cw_pkg::*; ();

   localparam int BYTECNT = 7;

   logic               clk_usb;
   logic               reset;
   reg_addr_t          reg_address_i;
   logic [BYTECNT-1:0] reg_bytecnt_i;
   reg_data_t          reg_datai_i;
   logic               reg_read_i;
   logic               reg_write_i;
   reg_data_t          reg_datao_o;
   trig_pins_t         trig_pins_i;
   trig_mods_t         trig_mods_i;
   logic               trigger_ext_o, trigger_capture_o;
   logic               decodeio_active_o, sad_active_o, edge_trigger_active_o;
   logic               targetpower_off_o, targetio_highz_o;

   int seed;
   int checks;
   int errors;

   cw_ctrl_top #(.pBYTECNT_SIZE(BYTECNT)) UUT (.*);

   always #20 clk_usb = ~clk_usb;   // 40 ns

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int c0, input int e0);
      $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
   endtask

   // one byte per write strobe that lands on the second edge
   task automatic reg_write(input reg_addr_t addr, input logic [BYTECNT-1:0] idx,
                            input reg_data_t data);
      @(posedge clk_usb);
      #2;
      reg_address_i = addr;
      reg_bytecnt_i = idx;
      reg_datai_i   = data;
      reg_write_i   = 1'b1;
      @(posedge clk_usb);
      #2;
      reg_write_i = 1'b0;
   endtask

   task automatic reg_read(input reg_addr_t addr, input logic [BYTECNT-1:0] idx,
                           input logic en, output reg_data_t data);
      @(posedge clk_usb);
      #2;
      reg_address_i = addr;
      reg_bytecnt_i = idx;
      reg_read_i    = en;
      @(negedge clk_usb);   // read path is combinational
      data = reg_datao_o;
      @(posedge clk_usb);
      #2;
      reg_read_i = 1'b0;
   endtask

   task automatic read_expect(input string name, input reg_addr_t addr,
                              input logic [BYTECNT-1:0] idx, input reg_data_t exp);
      reg_data_t rd;
      reg_read(addr, idx, 1'b1, rd);
      check(name, 32'(rd), 32'(exp));
   endtask

   task automatic wait_power(input logic level, input int max_cycles, output int waited);
      waited = 0;
      @(negedge clk_usb);
      while (targetpower_off_o !== level && waited < max_cycles) begin
         @(negedge clk_usb);
         waited++;
      end
      if (targetpower_off_o !== level) begin
         errors++;
         $display("timeout at %0t: targetpower_off_o did not reach %0b within %0d clocks",
                  $time, level, max_cycles);
      end
   endtask

   task automatic reset_readback();
      reg_data_t sp_exp [8] = '{8'd35, 8'd0, 8'hd0, 8'h07, 8'hcb, 8'h07, 8'd0, 8'd0};
      reg_data_t wr [8];
      reg_data_t rd;
      int        c0, e0, i;
      c0 = checks;
      e0 = errors;
      @(negedge clk_usb);
      check("targetpower_off_o", 32'(targetpower_off_o), 32'd0);
      check("targetio_highz_o", 32'(targetio_highz_o), 32'd0);
      check("active flags", 32'({decodeio_active_o, sad_active_o, edge_trigger_active_o}), 32'd0);
      check("reg_datao_o idle", 32'(reg_datao_o), 32'd0);
      read_expect("reg_datao_o trigsrc[0]", CW_TRIGSRC_ADDR, 7'd0, 8'h20);   // io4, OR
      read_expect("reg_datao_o trigsrc[1]", CW_TRIGSRC_ADDR, 7'd1, 8'h00);
      read_expect("reg_datao_o trigsrc[2]", CW_TRIGSRC_ADDR, 7'd2, 8'h00);   // past the end
      for (i = 0; i < 8; i++)
         read_expect("reg_datao_o softpower", SOFTPOWER_CONTROL_ADDR, 7'(i), sp_exp[i]);
      read_expect("reg_datao_o unknown addr", 8'd200, 7'd0, 8'h00);
      read_expect("reg_datao_o ioroute[5]", CW_IOROUTE_ADDR, 7'd5, 8'h00);
      for (i = 0; i < 8; i++) begin
         wr[i] = 8'($random(seed));
         reg_write(SOFTPOWER_CONTROL_ADDR, 7'(i), wr[i]);
      end
      for (i = 0; i < 8; i++)
         read_expect("reg_datao_o softpower wr", SOFTPOWER_CONTROL_ADDR, 7'(i), wr[i]);
      reg_write(CW_TRIGMOD_ADDR, 7'd0, 8'ha5);   // upper bits read back too
      read_expect("reg_datao_o trigmod", CW_TRIGMOD_ADDR, 7'd0, 8'ha5);
      reg_read(CW_TRIGMOD_ADDR, 7'd0, 1'b0, rd);
      check("reg_datao_o read low", 32'(rd), 32'd0);
      report_test("reset and read-back", c0, e0);
   endtask

   task automatic ext_combine();
      logic [13:0] en;     // enables in pin order
      logic [13:0] pins;
      logic        exp_or, exp_and, exp;
      int          c0, e0, mode, it, k, p;
      c0 = checks;
      e0 = errors;
      reg_write(CW_TRIGMOD_ADDR, 7'd0, 8'h00);   // EXT so capture follows too
      for (mode = 0; mode < 4; mode++) begin
         for (it = 0; it < 10; it++) begin
            en = (it == 0) ? 14'd0 : 14'($random(seed));   // first pass empty mask
            reg_write(CW_TRIGSRC_ADDR, 7'd0, {2'(mode), en[5:0]});
            reg_write(CW_TRIGSRC_ADDR, 7'd1, en[13:6]);
            for (k = 0; k < 4; k++) begin
               pins = 14'($random(seed));
               if (k == 0)
                  pins = pins | en;   // all enabled pins high
               @(posedge clk_usb);
               #2;
               trig_pins_i = pins;
               @(negedge clk_usb);
               exp_or  = 1'b0;
               exp_and = 1'b1;
               for (p = 0; p < 14; p++) begin
                  if (en[p]) begin   // a disabled pin leaves both results alone
                     exp_or  = exp_or | pins[p];
                     exp_and = exp_and & pins[p];
                  end
               end
               case (mode)
                  0:       exp = exp_or;
                  1:       exp = exp_and;
                  2:       exp = ~exp_and;
                  default: exp = 1'b0;
               endcase
               check("trigger_ext_o", 32'(trigger_ext_o), 32'(exp));
               check("trigger_capture_o", 32'(trigger_capture_o), 32'(exp));
            end
         end
      end
      report_test("external combine", c0, e0);
   endtask

   task automatic module_select();
      logic [5:0]  mods;
      logic [13:0] pins;
      logic        exp_cap;
      int          c0, e0, m, k;
      c0 = checks;
      e0 = errors;
      reg_write(CW_TRIGSRC_ADDR, 7'd0, 8'h20);   // ext = io4 alone
      reg_write(CW_TRIGSRC_ADDR, 7'd1, 8'h00);
      for (m = 0; m < 8; m++) begin
         reg_write(CW_TRIGMOD_ADDR, 7'd0, 8'(m));
         for (k = 0; k < 6; k++) begin
            mods = 6'($random(seed));
            pins = 14'($random(seed));
            @(posedge clk_usb);
            #2;
            trig_mods_i = mods;
            trig_pins_i = pins;
            @(negedge clk_usb);
            if (m == 0)
               exp_cap = pins[5];   // io4
            else if (m == 7)
               exp_cap = 1'b0;
            else
               exp_cap = mods[3'(m - 1)];
            check("trigger_capture_o", 32'(trigger_capture_o), 32'(exp_cap));
            check("decodeio_active_o", 32'(decodeio_active_o), 32'(m == 3));
            check("sad_active_o", 32'(sad_active_o), 32'(m == 2));
            check("edge_trigger_active_o", 32'(edge_trigger_active_o), 32'(m == 6));
         end
      end
      report_test("module select", c0, e0);
   endtask

   task automatic fast_power();
      int c0, e0, k;
      c0 = checks;
      e0 = errors;
      reg_write(CW_IOROUTE_ADDR, 7'd5, 8'h04);   // fast start, power on
      read_expect("reg_datao_o ioroute[5]", CW_IOROUTE_ADDR, 7'd5, 8'h04);
      reg_write(CW_IOROUTE_ADDR, 7'd5, 8'h06);   // power off
      @(negedge clk_usb);
      check("targetpower_off_o", 32'(targetpower_off_o), 32'd1);
      check("targetio_highz_o", 32'(targetio_highz_o), 32'd1);
      read_expect("reg_datao_o ioroute[5]", CW_IOROUTE_ADDR, 7'd5, 8'h06);
      reg_write(CW_IOROUTE_ADDR, 7'd5, 8'h04);
      for (k = 0; k < 20; k++) begin   // no pwm pulses in fast mode
         @(negedge clk_usb);
         check("targetpower_off_o", 32'(targetpower_off_o), 32'd0);
         check("targetio_highz_o", 32'(targetio_highz_o), 32'd0);
      end
      report_test("fast power switching", c0, e0);
   endtask

   task automatic soft_start();
      reg_data_t cfg [8] = '{8'd3, 8'd2, 8'd9, 8'd0, 8'd6, 8'd0, 8'd2, 8'd0};
      int        c0, e0, i, waited, highs, window;
      c0 = checks;
      e0 = errors;
      for (i = 0; i < 8; i++)
         reg_write(SOFTPOWER_CONTROL_ADDR, 7'(i), cfg[i]);
      reg_write(CW_IOROUTE_ADDR, 7'd5, 8'h02);   // power off, slow start
      @(negedge clk_usb);
      check("targetpower_off_o", 32'(targetpower_off_o), 32'd1);
      check("targetio_highz_o", 32'(targetio_highz_o), 32'd1);
      reg_write(CW_IOROUTE_ADDR, 7'd5, 8'h00);
      wait_power(1'b1, 10, waited);
      if (targetpower_off_o === 1'b1) begin
         highs  = 1;
         window = 70 - waited - 1;   // (3 + 2 + 2) * (9 + 1) clocks from the write
         for (i = 0; i < window; i++) begin
            @(negedge clk_usb);
            if (targetpower_off_o === 1'b1)
               highs++;
            check("targetio_highz_o", 32'(targetio_highz_o), 32'd0);
         end
         checks++;
         if (highs > 3 * 6 + 2 * 2 + 6) begin
            errors++;
            $display("soft start kept target power off for %0d clocks, limit is 28", highs);
         end
         for (i = 0; i < 20; i++) begin
            @(negedge clk_usb);
            check("targetpower_off_o", 32'(targetpower_off_o), 32'd0);
         end
      end
      report_test("soft start", c0, e0);
   endtask

   initial begin
      seed          = 69;
      checks        = 0;
      errors        = 0;
      clk_usb       = 1'b0;
      reset         = 1'b1;
      reg_address_i = '0;
      reg_bytecnt_i = '0;
      reg_datai_i   = '0;
      reg_read_i    = 1'b0;
      reg_write_i   = 1'b0;
      trig_pins_i   = '0;
      trig_mods_i   = '0;
      repeat (8) @(posedge clk_usb);
      #2;
      reset = 1'b0;
      reset_readback();
      ext_combine();
      module_select();
      fast_power();
      soft_start();
      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   // whole run guard
   initial begin
      #500_000;
      $display("timeout: the tests did not finish within 500 us");
      $display("Verification failed");
      $finish;
   end

endmodule

// ==== cw_ctrl_top.f ====
cw_pkg.sv
cw_regs.sv
trig_route.sv
softstart_pwm.sv
cw_ctrl_top.sv
cw_ctrl_top_chk.sv
cw_ctrl_top_tb.sv

// ==== Makefile ====
TOP = cw_ctrl_top_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f cw_ctrl_top.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
